// ==== design/pipe_ctrl_defs.svh ====
/*
 * Global sizes, reset values and CSR map of the pipeline control block.
 * Include wherever a width, reset value or CSR address is needed.
 */
`ifndef PIPE_CTRL_DEFS_SVH
`define PIPE_CTRL_DEFS_SVH

`define XLEN        32            // data and address width.
`define RESET_PC    32'h0000_0200 // first fetch after reset.
`define MTVEC_RESET 32'h0000_0100 // trap vector until software moves it.

// apb byte addresses of the machine csrs.
`define CSR_MSTATUS 32'h0000_0000
`define CSR_MIE     32'h0000_0004
`define CSR_MTVEC   32'h0000_0008
`define CSR_MEPC    32'h0000_000C // read only from apb.
`define CSR_MCAUSE  32'h0000_0010 // read only from apb.
`define CSR_MTVAL   32'h0000_0014 // read only from apb.

`endif

// ==== design/pipe_ctrl_pkg.sv ====
/*
 * Shared types of the pipeline control block.
 * Refer to them by scoped name, pipe_ctrl_pkg::name.
 */
`default_nettype none
`include "pipe_ctrl_defs.svh"

package pipe_ctrl_pkg;

  // status flags from the datapath.
  typedef struct packed {
    logic dren;
    logic dwen;
    logic jump;
    logic branch;
    logic mispredict;
    logic i_mem_busy;
    logic d_mem_busy;
    logic halt;
    logic ret;
  } pipe_status_t;

  // fetch stage faults first, then execute stage.
  typedef struct packed {
    logic fault_insn;
    logic mal_insn;
    logic illegal_insn;
    logic fault_l;
    logic mal_l;
    logic fault_s;
    logic mal_s;
    logic breakpoint;
    logic env_m;
  } exc_flags_t;

  typedef struct packed {
    logic pc_en;
    logic npc_sel;
    logic if_ex_flush;
    logic if_ex_stall;
    logic iren;
    logic wb_enable;
  } hazard_ctrl_t;

  // hazard unit to trap unit.
  typedef struct packed {
    logic             take_exc;
    logic             take_intr;
    logic             ret;
    exc_flags_t       exc;
    logic [`XLEN-1:0] epc;
    logic [`XLEN-1:0] badaddr;
  } trap_req_t;

  // trap unit back to hazard unit and fetch.
  typedef struct packed {
    logic             insert_pc;
    logic [`XLEN-1:0] priv_pc;
    logic             intr_pending;
    logic             busy;
  } redirect_t;

  typedef enum logic [31:0] {
    CAUSE_MAL_INSN   = 32'd0,
    CAUSE_FAULT_INSN = 32'd1,
    CAUSE_ILLEGAL    = 32'd2,
    CAUSE_BREAKPOINT = 32'd3,
    CAUSE_MAL_L      = 32'd4,
    CAUSE_FAULT_L    = 32'd5,
    CAUSE_MAL_S      = 32'd6,
    CAUSE_FAULT_S    = 32'd7,
    CAUSE_ENV_M      = 32'd11,
    CAUSE_M_EXT_INTR = 32'h8000_000B // interrupt bit set.
  } cause_e;

  typedef struct packed {
    logic             psel;
    logic             penable;
    logic             pwrite;
    logic [`XLEN-1:0] paddr;
    logic [`XLEN-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [`XLEN-1:0] prdata;
    logic             pready;
    logic             pslverr;
  } apb_rsp_t;

endpackage

`default_nettype wire

// ==== design/hazard_unit.sv ====
/*
 * Hazard unit of the two stage pipeline.
 * Turns datapath status, exceptions and trap redirects into stall, flush,
 * pc enable and next pc select, and forwards trap requests to the trap unit.
 * Purely combinational; the clock only samples an assertion.
 */
`timescale 1ns/1ps
`default_nettype none
`include "pipe_ctrl_defs.svh"

module hazard_unit (
  input  logic                        clk,
  input  logic                        reset,
  input  pipe_ctrl_pkg::pipe_status_t status,
  input  pipe_ctrl_pkg::exc_flags_t   exc,
  input  pipe_ctrl_pkg::redirect_t    redirect,
  input  logic                        token_ex,
  input  logic [`XLEN-1:0]            epc_f,
  input  logic [`XLEN-1:0]            epc_e,
  input  logic [`XLEN-1:0]            badaddr_f,
  input  logic [`XLEN-1:0]            badaddr_e,
  output pipe_ctrl_pkg::hazard_ctrl_t ctrl,
  output pipe_ctrl_pkg::trap_req_t    trap_req
);

  logic dmem_access;
  logic branch_jump;
  logic wait_for_imem;
  logic wait_for_dmem;
  logic e_ex_stage;      // execute stage exception.
  logic e_f_stage;       // fetch stage exception.
  logic intr;
  logic ex_flush_hazard;
  logic iren;
  logic base_stall;

  assign dmem_access   = status.dren | status.dwen;
  assign branch_jump   = status.jump | (status.branch & status.mispredict);
  assign iren          = ~intr; // no fetch request while taking an interrupt.
  assign wait_for_imem = iren & status.i_mem_busy;
  assign wait_for_dmem = dmem_access & status.d_mem_busy;

  // execute faults only count with a live instruction in execute.
  assign e_ex_stage = token_ex & (exc.illegal_insn | exc.fault_l | exc.mal_l |
                                  exc.fault_s | exc.mal_s | exc.breakpoint | exc.env_m);
  assign e_f_stage  = exc.fault_insn | exc.mal_insn;
  assign intr       = ~e_ex_stage & ~e_f_stage & redirect.intr_pending; // exceptions first.

  // a pending load or store holds off every trap.
  assign ex_flush_hazard = ((intr | e_f_stage | e_ex_stage) & ~wait_for_dmem) | status.ret;
  assign base_stall      = wait_for_dmem | (wait_for_imem & ~dmem_access) | status.halt;

  always_comb begin
    ctrl.npc_sel     = branch_jump;
    ctrl.pc_en       = (~wait_for_dmem & ~wait_for_imem & ~status.halt & ~ex_flush_hazard) |
                       branch_jump | redirect.insert_pc | status.ret;
    ctrl.if_ex_flush = ex_flush_hazard | branch_jump |
                       (wait_for_imem & dmem_access & ~status.d_mem_busy); // data done, drop fetch.
    ctrl.if_ex_stall = base_stall & ~ex_flush_hazard;
    ctrl.iren        = iren;
    ctrl.wb_enable   = ~ctrl.if_ex_stall | status.jump | status.branch; // two stages only.
  end

  // trap notification.
  always_comb begin
    trap_req.take_exc  = (e_ex_stage | e_f_stage) & ~wait_for_dmem;
    trap_req.take_intr = intr & ~wait_for_dmem;
    trap_req.ret       = status.ret;
    trap_req.exc       = exc;
    trap_req.epc       = e_ex_stage ? epc_e : epc_f; // fetch pc for fetch faults and irqs.
    trap_req.badaddr   = (exc.mal_insn | exc.fault_insn) ? badaddr_f : badaddr_e;
  end

  // a redirect and a hold must never meet on an enabled pc.
  a_no_branch_on_stall : assert property (@(posedge clk) disable iff (reset)
    ctrl.pc_en |-> !(ctrl.npc_sel && ctrl.if_ex_stall));

endmodule

`default_nettype wire

// ==== design/fetch_pc.sv ====
/*
 * Fetch stage pc and the fetch to execute latch.
 * Next pc priority: trap redirect, branch target, pc + 4.
 * The latch carries the fetch pc and a valid token into execute.
 */
`timescale 1ns/1ps
`default_nettype none
`include "pipe_ctrl_defs.svh"

module fetch_pc (
  input  logic                        clk,
  input  logic                        reset,
  input  pipe_ctrl_pkg::hazard_ctrl_t ctrl,
  input  pipe_ctrl_pkg::redirect_t    redirect,
  input  logic [`XLEN-1:0]            branch_target,
  output logic [`XLEN-1:0]            pc,
  output logic [`XLEN-1:0]            epc_e,
  output logic                        token_ex
);

  logic [`XLEN-1:0] npc;
  logic             latch_en;

  // three way next pc mux.
  always_comb begin
    if (redirect.insert_pc) begin
      npc = redirect.priv_pc;  // trap vector or mepc.
    end else if (ctrl.npc_sel) begin
      npc = branch_target;
    end else begin
      npc = pc + `XLEN'd4;     // sequential.
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= `RESET_PC;
    end else if (ctrl.pc_en) begin
      pc <= npc;
    end
  end

  assign latch_en = ~ctrl.if_ex_stall & ~ctrl.if_ex_flush;

  // token says execute holds a real instruction.
  always_ff @(posedge clk) begin
    if (reset) begin
      token_ex <= 1'b0;
    end else if (ctrl.if_ex_flush) begin
      token_ex <= 1'b0;       // bubble into execute.
    end else if (!ctrl.if_ex_stall) begin
      token_ex <= 1'b1;
    end
  end

  // pc of the instruction in execute, meaningful only with the token.
  always_ff @(posedge clk) begin
    if (latch_en) begin
      epc_e <= pc;
    end
  end

  // fetch addresses are always whole words.
  a_pc_aligned : assert property (@(posedge clk) disable iff (reset)
    pc[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== design/trap_unit.sv ====
/*
 * Machine mode trap unit.
 * Gates the external interrupt, picks the trap cause, records mepc,
 * mcause and mtval, and redirects fetch for one cycle after a trap or
 * a return. The csr block holds the enables and reads the record back.
 */
`timescale 1ns/1ps
`default_nettype none
`include "pipe_ctrl_defs.svh"

module trap_unit (
  input  logic                     clk,
  input  logic                     reset,
  input  pipe_ctrl_pkg::trap_req_t trap_req,
  input  logic                     irq,
  input  logic [`XLEN-1:0]         mtvec,
  input  logic                     mstatus_mie,
  input  logic                     mie_meie,
  output pipe_ctrl_pkg::redirect_t redirect,
  output logic [`XLEN-1:0]         mepc,
  output logic [`XLEN-1:0]         mcause,
  output logic [`XLEN-1:0]         mtval,
  output logic                     mstatus_upd,
  output logic                     mstatus_mie_next
);

  pipe_ctrl_pkg::cause_e cause;
  logic                  insert_q;  // redirect cycle, doubles as busy.
  logic [`XLEN-1:0]      priv_pc_q;
  logic                  mpie;      // previous interrupt enable.
  logic                  trap;
  logic                  accept;

  assign trap   = ~insert_q & (trap_req.take_exc | trap_req.take_intr);
  assign accept = trap | (~insert_q & trap_req.ret); // nothing new while busy.

  // fixed exception priority, interrupt last.
  always_comb begin
    if (!trap_req.take_exc)         cause = pipe_ctrl_pkg::CAUSE_M_EXT_INTR;
    else if (trap_req.exc.fault_insn)   cause = pipe_ctrl_pkg::CAUSE_FAULT_INSN;
    else if (trap_req.exc.mal_insn)     cause = pipe_ctrl_pkg::CAUSE_MAL_INSN;
    else if (trap_req.exc.illegal_insn) cause = pipe_ctrl_pkg::CAUSE_ILLEGAL;
    else if (trap_req.exc.breakpoint)   cause = pipe_ctrl_pkg::CAUSE_BREAKPOINT;
    else if (trap_req.exc.env_m)        cause = pipe_ctrl_pkg::CAUSE_ENV_M;
    else if (trap_req.exc.mal_l)        cause = pipe_ctrl_pkg::CAUSE_MAL_L;
    else if (trap_req.exc.fault_l)      cause = pipe_ctrl_pkg::CAUSE_FAULT_L;
    else if (trap_req.exc.mal_s)        cause = pipe_ctrl_pkg::CAUSE_MAL_S;
    else                                cause = pipe_ctrl_pkg::CAUSE_FAULT_S;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      insert_q <= 1'b0;
      mpie     <= 1'b0;
      mepc     <= '0;
      mcause   <= '0;
      mtval    <= '0;
    end else begin
      insert_q <= accept; // one cycle pulse.
      if (trap) begin
        mpie   <= mstatus_mie;      // stash the global enable.
        mepc   <= trap_req.epc;
        mcause <= cause;
        mtval  <= trap_req.take_exc ? trap_req.badaddr : '0;
      end else if (accept) begin
        mpie   <= 1'b1;             // return re-arms the stash.
      end
    end
  end

  // redirect target, only looked at while insert_q is high.
  always_ff @(posedge clk) begin
    if (accept) begin
      priv_pc_q <= trap ? mtvec : mepc;
    end
  end

  assign mstatus_upd      = accept;
  assign mstatus_mie_next = trap ? 1'b0 : mpie; // clear on trap, restore on ret.

  always_comb begin
    redirect.insert_pc    = insert_q;
    redirect.priv_pc      = priv_pc_q;
    redirect.intr_pending = irq & mie_meie & mstatus_mie;
    redirect.busy         = insert_q;
  end

  // a redirect always lands on a whole word.
  a_redirect_aligned : assert property (@(posedge clk) disable iff (reset)
    redirect.insert_pc |-> redirect.priv_pc[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== design/csr_apb.sv ====
/*
 * Machine csrs behind a zero wait APB slave.
 * mtvec, mie and mstatus are writable, the trap record is read only.
 * Response is registered in the setup phase and valid in the access phase.
 */
`timescale 1ns/1ps
`default_nettype none
`include "pipe_ctrl_defs.svh"

module csr_apb (
  input  logic                    clk,
  input  logic                    reset,
  input  pipe_ctrl_pkg::apb_req_t apb_req,
  output pipe_ctrl_pkg::apb_rsp_t apb_rsp,
  input  logic [`XLEN-1:0]        mepc,
  input  logic [`XLEN-1:0]        mcause,
  input  logic [`XLEN-1:0]        mtval,
  input  logic                    mstatus_upd,
  input  logic                    mstatus_mie_next,
  output logic [`XLEN-1:0]        mtvec,
  output logic                    mstatus_mie,
  output logic                    mie_meie
);

  logic [`XLEN-1:0] rdata;
  logic             hit;     // address decodes.
  logic             ro;      // trap record, no writes.
  logic             err;
  logic             setup;
  logic             wr;

  always_comb begin
    hit = 1'b1;
    ro  = 1'b0;
    case (apb_req.paddr)
      `CSR_MSTATUS: rdata = {{(`XLEN-4){1'b0}}, mstatus_mie, 3'b000}; // mie at bit 3.
      `CSR_MIE:     rdata = {{(`XLEN-12){1'b0}}, mie_meie, 11'd0};    // meie at bit 11.
      `CSR_MTVEC:   rdata = mtvec;
      `CSR_MEPC:    begin rdata = mepc;   ro = 1'b1; end
      `CSR_MCAUSE:  begin rdata = mcause; ro = 1'b1; end
      `CSR_MTVAL:   begin rdata = mtval;  ro = 1'b1; end
      default:      begin rdata = '0;     hit = 1'b0; end
    endcase
  end

  assign err   = ~hit | (ro & apb_req.pwrite);
  assign setup = apb_req.psel & ~apb_req.penable;
  assign wr    = apb_req.psel & apb_req.penable & apb_req.pwrite & ~err;

  always_ff @(posedge clk) begin
    if (reset) begin
      apb_rsp.pready  <= 1'b0;
      apb_rsp.pslverr <= 1'b0;
      mtvec           <= `MTVEC_RESET;
      mstatus_mie     <= 1'b0;
      mie_meie        <= 1'b0;
    end else begin
      apb_rsp.pready  <= setup;        // high for exactly the access phase.
      apb_rsp.pslverr <= setup & err;
      if (wr && apb_req.paddr == `CSR_MTVEC) mtvec <= {apb_req.pwdata[`XLEN-1:2], 2'b00};
      if (wr && apb_req.paddr == `CSR_MIE)   mie_meie <= apb_req.pwdata[11];
      if (mstatus_upd) begin
        mstatus_mie <= mstatus_mie_next; // hardware wins over software.
      end else if (wr && apb_req.paddr == `CSR_MSTATUS) begin
        mstatus_mie <= apb_req.pwdata[3];
      end
    end
  end

  // read data sampled with the setup phase.
  always_ff @(posedge clk) begin
    if (setup) apb_rsp.prdata <= rdata;
  end

  a_penable_psel : assert property (@(posedge clk) disable iff (reset)
    apb_req.penable |-> apb_req.psel);

endmodule

`default_nettype wire

// ==== design/pipe_ctrl_top.sv ====
/*
 * Top of the pipeline control block.
 * Connects hazard unit, fetch pc, trap unit and the APB csr block.
 * The datapath drives status and exceptions and consumes pc and ctrl.
 */
`timescale 1ns/1ps
`default_nettype none
`include "pipe_ctrl_defs.svh"

module pipe_ctrl_top (
  input  logic                        clk,
  input  logic                        reset,
  input  pipe_ctrl_pkg::pipe_status_t status,
  input  pipe_ctrl_pkg::exc_flags_t   exc,
  input  logic [`XLEN-1:0]            branch_target,
  input  logic [`XLEN-1:0]            badaddr_f,
  input  logic [`XLEN-1:0]            badaddr_e,
  input  logic                        irq,
  input  pipe_ctrl_pkg::apb_req_t     apb_req,
  output pipe_ctrl_pkg::apb_rsp_t     apb_rsp,
  output logic [`XLEN-1:0]            pc,
  output pipe_ctrl_pkg::hazard_ctrl_t ctrl
);

  pipe_ctrl_pkg::redirect_t redirect;
  pipe_ctrl_pkg::trap_req_t trap_req;
  logic                     token_ex;
  logic [`XLEN-1:0]         epc_e;
  logic [`XLEN-1:0]         mtvec, mepc, mcause, mtval;
  logic                     mstatus_mie, mie_meie;
  logic                     mstatus_upd, mstatus_mie_next;

  hazard_unit u_hazard (.clk, .reset, .status, .exc, .redirect, .token_ex,
                        .epc_f(pc), .epc_e, .badaddr_f, .badaddr_e, .ctrl, .trap_req);

  fetch_pc u_fetch (.clk, .reset, .ctrl, .redirect, .branch_target, .pc, .epc_e, .token_ex);

  trap_unit u_trap (.clk, .reset, .trap_req, .irq, .mtvec, .mstatus_mie, .mie_meie,
                    .redirect, .mepc, .mcause, .mtval, .mstatus_upd, .mstatus_mie_next);

  csr_apb u_csr (.clk, .reset, .apb_req, .apb_rsp, .mepc, .mcause, .mtval,
                 .mstatus_upd, .mstatus_mie_next, .mtvec, .mstatus_mie, .mie_meie);

endmodule

`default_nettype wire

// ==== bench/pipe_ctrl_tb.sv ====
/*
 * Table driven testbench of the pipeline control top.
 * Stands in for the datapath: each row drives status, exceptions and irq
 * for one cycle, then checks ctrl in that cycle and the pc after the edge.
 * APB transfers set up the csrs and read back the trap record.
 */
`timescale 1ns/1ps
`default_nettype none
`include "pipe_ctrl_defs.svh"

module pipe_ctrl_tb;

  localparam int n_rows         = 23;
  localparam int reset_cycles   = 4;
  localparam int n_apb          = 16;
  localparam int timeout_cycles = n_rows * 3 + reset_cycles + 2 * n_apb + 20;
  localparam logic [`XLEN-1:0] mtvec_prog = 32'h0000_0400;
  localparam logic [`XLEN-1:0] bad_e      = 32'hDEAD_BEE0;

  // ctrl bits from the msb are pc_en, npc_sel, flush, stall, iren, wb_enable.
  localparam pipe_ctrl_pkg::hazard_ctrl_t ctrl_run   = 6'b100011; // free running.
  localparam pipe_ctrl_pkg::hazard_ctrl_t ctrl_hold  = 6'b000110; // stall, pc held.
  localparam pipe_ctrl_pkg::hazard_ctrl_t ctrl_drop  = 6'b001011; // bubble, pc held.
  localparam pipe_ctrl_pkg::hazard_ctrl_t ctrl_redir = 6'b111011; // branch or jump.
  localparam pipe_ctrl_pkg::hazard_ctrl_t ctrl_intr  = 6'b001001; // no fetch request.
  localparam pipe_ctrl_pkg::hazard_ctrl_t ctrl_ret   = 6'b101011; // pc forced on.

  logic                        clk = 1'b0;
  logic                        reset;
  pipe_ctrl_pkg::pipe_status_t status;
  pipe_ctrl_pkg::exc_flags_t   exc;
  logic [`XLEN-1:0]            branch_target;
  logic [`XLEN-1:0]            badaddr_f;
  logic [`XLEN-1:0]            badaddr_e;
  logic                        irq;
  pipe_ctrl_pkg::apb_req_t     apb_req;
  pipe_ctrl_pkg::apb_rsp_t     apb_rsp;
  logic [`XLEN-1:0]            pc;
  pipe_ctrl_pkg::hazard_ctrl_t ctrl;

  // stimulus table, one entry per cycle.
  string                        row_name     [n_rows];
  pipe_ctrl_pkg::pipe_status_t  row_status   [n_rows];
  pipe_ctrl_pkg::exc_flags_t    row_exc      [n_rows];
  logic                         row_irq      [n_rows];
  logic [`XLEN-1:0]             row_target   [n_rows];
  logic [`XLEN-1:0]             row_badaddr_f[n_rows];
  logic [`XLEN-1:0]             row_badaddr_e[n_rows];
  pipe_ctrl_pkg::hazard_ctrl_t  row_ctrl     [n_rows];
  logic [`XLEN-1:0]             row_pc       [n_rows]; // pc after the edge.

  int               n_built = 0;
  int               seg1_last;
  int               seg2_last;
  logic [`XLEN-1:0] exp_mepc_exc; // execute pc of the faulting instruction.
  logic [`XLEN-1:0] exp_mepc_irq; // fetch pc when the irq was taken.
  integer           seed = 33;
  int               checks = 0;
  int               errors = 0;
  int               cycles = 0;

  pipe_ctrl_top dut (.clk, .reset, .status, .exc, .branch_target, .badaddr_f, .badaddr_e,
                     .irq, .apb_req, .apb_rsp, .pc, .ctrl);

  always #5 clk = ~clk; // 10 ns period.

  // run limit.
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= timeout_cycles) begin
      $display("timeout after %0d cycles, the test sequence did not finish", cycles);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  task automatic check_word(input string test, input string what,
                            input logic [`XLEN-1:0] expected, input logic [`XLEN-1:0] actual);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("Mismatch %s %s: expected %h, actual %h", test, what, expected, actual);
    end
  endtask

  task automatic add_row(input string name, input pipe_ctrl_pkg::pipe_status_t st,
                         input pipe_ctrl_pkg::exc_flags_t ex, input logic irq_in,
                         input logic [`XLEN-1:0] target, input logic [`XLEN-1:0] bad_f,
                         input logic [`XLEN-1:0] bad_e, input pipe_ctrl_pkg::hazard_ctrl_t c,
                         input logic [`XLEN-1:0] next_pc);
    row_name[n_built]      = name;
    row_status[n_built]    = st;
    row_exc[n_built]       = ex;
    row_irq[n_built]       = irq_in;
    row_target[n_built]    = target;
    row_badaddr_f[n_built] = bad_f;
    row_badaddr_e[n_built] = bad_e;
    row_ctrl[n_built]      = c;
    row_pc[n_built]        = next_pc;
    n_built++;
  endtask

  // expected pc tracked by hand: +4, branch target, or trap redirect.
  task automatic build_table();
    pipe_ctrl_pkg::pipe_status_t st;
    pipe_ctrl_pkg::exc_flags_t   ex;
    logic [`XLEN-1:0]            pcm;
    int                          k;
    pcm = `RESET_PC;
    ex  = '0;
    for (int j = 0; j < 3; j++) begin
      pcm = pcm + 4;
      add_row($sformatf("seq_%0d", j), '0, ex, 1'b0, '0, '0, '0, ctrl_run, pcm);
    end
    for (int j = 0; j < 4; j++) begin
      k  = $random(seed) & 3; // busy flag mix.
      st = '0;
      case (k)
        0: begin st.dren = 1'b1; st.d_mem_busy = 1'b1; end
        1: begin st.dwen = 1'b1; st.d_mem_busy = 1'b1; st.i_mem_busy = 1'b1; end
        2: st.i_mem_busy = 1'b1; // imem wait, no data access.
        default: st.halt = 1'b1;
      endcase
      add_row($sformatf("stall_%0d", j), st, ex, 1'b0, '0, '0, '0, ctrl_hold, pcm);
    end
    st = '0;
    st.i_mem_busy = 1'b1;
    st.dren       = 1'b1; // load done, fetch still busy.
    add_row("imem_drop", st, ex, 1'b0, '0, '0, '0, ctrl_drop, pcm);
    pcm = pcm + 4;
    add_row("seq_3", '0, ex, 1'b0, '0, '0, '0, ctrl_run, pcm);
    st = '0;
    st.branch = 1'b1;
    pcm = pcm + 4; // predicted right, target ignored.
    add_row("br_predicted", st, ex, 1'b0, 32'h300, '0, '0, ctrl_run, pcm);
    st.mispredict = 1'b1;
    pcm = 32'h300;
    add_row("br_mispredict", st, ex, 1'b0, 32'h300, '0, '0, ctrl_redir, pcm);
    st = '0;
    st.jump = 1'b1;
    pcm = 32'h380;
    add_row("jump", st, ex, 1'b0, 32'h380, '0, '0, ctrl_redir, pcm);
    exp_mepc_exc = pcm; // latched into execute by the next edge.
    pcm = pcm + 4;
    add_row("seq_4", '0, ex, 1'b0, '0, '0, '0, ctrl_run, pcm);
    ex.illegal_insn = 1'b1;
    ex.mal_l        = 1'b1; // lower priority, must lose.
    add_row("illegal_mal_l", '0, ex, 1'b0, '0, 32'h0000_0BAD, bad_e, ctrl_drop, pcm);
    ex  = '0;
    pcm = mtvec_prog; // second edge after the fault.
    add_row("trap_redirect", '0, ex, 1'b0, '0, '0, '0, ctrl_run, pcm);
    pcm = pcm + 4;
    add_row("vector_0", '0, ex, 1'b0, '0, '0, '0, ctrl_run, pcm);
    seg1_last = n_built - 1;

    exp_mepc_irq = pcm;
    add_row("irq_take", '0, ex, 1'b1, '0, '0, '0, ctrl_intr, pcm);
    pcm = mtvec_prog;
    add_row("irq_redirect", '0, ex, 1'b1, '0, '0, '0, ctrl_run, pcm);
    pcm = pcm + 4; // irq still high, global enable now off.
    add_row("irq_masked", '0, ex, 1'b1, '0, '0, '0, ctrl_run, pcm);
    pcm = pcm + 4;
    add_row("handler", '0, ex, 1'b0, '0, '0, '0, ctrl_run, pcm);
    seg2_last = n_built - 1;

    st = '0;
    st.ret = 1'b1;
    pcm = pcm + 4; // pc forced on during ret.
    add_row("ret", st, ex, 1'b0, '0, '0, '0, ctrl_ret, pcm);
    pcm = exp_mepc_irq;
    add_row("ret_redirect", '0, ex, 1'b0, '0, '0, '0, ctrl_run, pcm);
    pcm = pcm + 4;
    add_row("after_ret", '0, ex, 1'b0, '0, '0, '0, ctrl_run, pcm);
  endtask

  // park the pipe on halt so the pc stays put.
  task automatic hold_pipe();
    pipe_ctrl_pkg::pipe_status_t st;
    st      = '0;
    st.halt = 1'b1;
    status <= st;
    exc    <= '0;
    irq    <= 1'b0;
  endtask

  task automatic run_rows(input int first, input int last);
    for (int i = first; i <= last; i++) begin
      @(posedge clk);
      status        <= row_status[i];
      exc           <= row_exc[i];
      irq           <= row_irq[i];
      branch_target <= row_target[i];
      badaddr_f     <= row_badaddr_f[i];
      badaddr_e     <= row_badaddr_e[i];
      apb_req       <= '0;
      @(negedge clk);
      if (i > first) check_word(row_name[i-1], "pc", row_pc[i-1], pc);
      check_word(row_name[i], "ctrl", {26'd0, row_ctrl[i]}, {26'd0, ctrl});
    end
    @(posedge clk);
    hold_pipe();
    @(negedge clk);
    check_word(row_name[last], "pc", row_pc[last], pc);
  endtask

  // setup then access phase, sampled mid access cycle.
  task automatic bus_transfer(input string name, input logic write, input logic [`XLEN-1:0] addr,
                              input logic [`XLEN-1:0] wdata, output logic [`XLEN-1:0] rdata,
                              output logic err);
    @(posedge clk);
    apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
    @(posedge clk);
    apb_req.penable <= 1'b1;
    @(negedge clk);
    assert (apb_rsp.pready === 1'b1) else begin
      errors++;
      $display("%s: pready was not high in the APB access phase", name);
    end
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
  endtask

  task automatic csr_write(input string name, input logic [`XLEN-1:0] addr,
                           input logic [`XLEN-1:0] data, input logic exp_err);
    logic [`XLEN-1:0] rdata;
    logic             err;
    bus_transfer(name, 1'b1, addr, data, rdata, err);
    check_word(name, "pslverr", {31'd0, exp_err}, {31'd0, err});
  endtask

  task automatic csr_read(input string name, input logic [`XLEN-1:0] addr,
                          input logic [`XLEN-1:0] expected);
    logic [`XLEN-1:0] rdata;
    logic             err;
    bus_transfer(name, 1'b0, addr, '0, rdata, err);
    check_word(name, "pslverr", 32'd0, {31'd0, err});
    check_word(name, "prdata", expected, rdata);
  endtask

  initial begin
    reset         = 1'b1;
    status        = '0;
    status.halt   = 1'b1; // pc frozen until the table starts.
    exc           = '0;
    irq           = 1'b0;
    branch_target = '0;
    badaddr_f     = '0;
    badaddr_e     = '0;
    apb_req       = '0;
    build_table();
    repeat (reset_cycles) @(posedge clk);
    reset <= 1'b0;

    csr_write("set_mtvec", `CSR_MTVEC, mtvec_prog, 1'b0);
    csr_write("set_mie", `CSR_MIE, 32'h0000_0800, 1'b0);         // meie.
    csr_write("set_mstatus", `CSR_MSTATUS, 32'h0000_0008, 1'b0); // global enable.

    run_rows(0, seg1_last);
    csr_read("exc_mepc", `CSR_MEPC, exp_mepc_exc);
    csr_read("exc_mcause", `CSR_MCAUSE, 32'd2);  // illegal instruction.
    csr_read("exc_mtval", `CSR_MTVAL, bad_e);
    csr_read("exc_mstatus", `CSR_MSTATUS, 32'd0); // enable cleared by the trap.
    csr_write("reenable", `CSR_MSTATUS, 32'h0000_0008, 1'b0);

    run_rows(seg1_last + 1, seg2_last);
    csr_read("irq_mstatus", `CSR_MSTATUS, 32'd0);
    csr_read("irq_mcause", `CSR_MCAUSE, 32'h8000_000B); // machine external irq.
    csr_read("irq_mepc", `CSR_MEPC, exp_mepc_irq);

    run_rows(seg2_last + 1, n_rows - 1);
    csr_read("ret_mstatus", `CSR_MSTATUS, 32'h0000_0008); // restored.

    // bus errors leave the registers alone.
    csr_write("mcause_ro", `CSR_MCAUSE, 32'h0000_0123, 1'b1);
    csr_read("mcause_kept", `CSR_MCAUSE, 32'h8000_000B);
    csr_write("unknown_addr", 32'h0000_0040, 32'hFFFF_FFFF, 1'b1);
    csr_read("mtvec_kept", `CSR_MTVEC, mtvec_prog);
    @(posedge clk);
    apb_req <= '0;

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+design
design/pipe_ctrl_pkg.sv
design/hazard_unit.sv
design/fetch_pc.sv
design/trap_unit.sv
design/csr_apb.sv
design/pipe_ctrl_top.sv
bench/pipe_ctrl_tb.sv

// ==== Bender.yml ====
package:
  name: pipe_ctrl

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/pipe_ctrl_pkg.sv
      - design/hazard_unit.sv
      - design/fetch_pc.sv
      - design/trap_unit.sv
      - design/csr_apb.sv
      - design/pipe_ctrl_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - bench/pipe_ctrl_tb.sv
